/* list.f */
+incdir+.
tmds_pkg.sv
video_pkg.sv
tmds_deser.sv
tmds_decode.sv
line_buffer.sv
line_reader.sv
tmds_line_rx.sv
tb_tmds_line_rx.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_tmds_line_rx
FILELIST  = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* tb_tmds_model.svh */
`ifndef TB_TMDS_MODEL_SVH
`define TB_TMDS_MODEL_SVH

logic [31:0] lfsr_q;
int          enc_cnt;

////////////////////////////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////////////////////////////

// Fibonacci LFSR with taps 32, 22, 2 and 1. One step for every bit taken.
function automatic int unsigned rand_bits(input int n);
  int unsigned r;
  r = 0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
    r      = {r[30:0], lfsr_q[0]};
  end
  return r;
endfunction

////////////////////////////////////////////////////////////////////////////
// TMDS encoder
////////////////////////////////////////////////////////////////////////////

function automatic int ones(input logic [7:0] v);
  int n;
  n = 0;
  for (int i = 0; i < 8; i++) begin
    if (v[i]) begin
      n++;
    end
  end
  return n;
endfunction

// Transition minimizing stage first, then DC balance against enc_cnt.
function automatic logic [9:0] tmds_encode(input logic [7:0] d);
  logic [8:0] qm;
  logic [9:0] q;
  logic       use_xnor;
  int         bal;
  use_xnor = (ones(d) > 4) || (ones(d) == 4 && !d[0]);
  qm[0]    = d[0];
  for (int i = 1; i < 8; i++) begin
    qm[i] = use_xnor ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
  end
  qm[8] = !use_xnor;
  // Ones minus zeros of the low byte.
  bal = 2 * ones(qm[7:0]) - 8;
  if (enc_cnt == 0 || bal == 0) begin
    q = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
    enc_cnt += qm[8] ? bal : -bal;
  end else if ((enc_cnt > 0) == (bal > 0)) begin
    q = {1'b1, qm[8], ~qm[7:0]};
    enc_cnt += (qm[8] ? 2 : 0) - bal;
  end else begin
    q = {1'b0, qm[8], qm[7:0]};
    enc_cnt += bal - (qm[8] ? 0 : 2);
  end
  return q;
endfunction

// A control period restarts the disparity count.
function automatic logic [9:0] ctrl_token(input logic [1:0] c);
  enc_cnt = 0;
  case (c)
    2'b00:   return tok_c00;
    2'b01:   return tok_c01;
    2'b10:   return tok_c10;
    default: return tok_c11;
  endcase
endfunction

`endif

/* tb_tmds_line_rx.sv */
`timescale 1ns/10ps

module tb_tmds_line_rx import tmds_pkg::*, video_pkg::*; ();

  localparam int n_lines  = 8;
  localparam int long_len = int'(line_max) + 5;

  logic       clk;
  logic       rst_n;
  logic       serial_bit;
  logic       bit_en;
  logic       locked;
  sync_t      sync;
  logic       pix_valid;
  logic       line_end;
  logic [7:0] pix_data;

  logic [9:0] sym_q[$];
  logic       close_q[$];
  logic [7:0] exp_byte_q[$];
  int         exp_len_q[$];
  logic [1:0] exp_sync_q[$];
  logic [1:0] exp_sync;
  int         lead_bits;
  int         total_bits;
  int         lines_sent;
  int         lines_out;
  int         pix_idx;
  int         cur_len;

  `include "tb_tmds_model.svh"

  tmds_line_rx dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .serial_bit (serial_bit),
    .bit_en     (bit_en),
    .locked     (locked),
    .sync       (sync),
    .pix_valid  (pix_valid),
    .line_end   (line_end),
    .pix_data   (pix_data)
  );

  always #4 clk = ~clk;

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_with(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and expected lines
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_ctrl(input logic [1:0] c, input int n, input logic closes);
    for (int i = 0; i < n; i++) begin
      sym_q.push_back(ctrl_token(c));
      close_q.push_back(closes && i == 0);
    end
  endtask

  // Bytes past line_max are sent but never expected back.
  task automatic add_line(input int len);
    logic [7:0] b;
    for (int i = 0; i < len; i++) begin
      b = 8'(rand_bits(8));
      sym_q.push_back(tmds_encode(b));
      close_q.push_back(1'b0);
      if (i < int'(line_max)) begin
        exp_byte_q.push_back(b);
      end
    end
    exp_len_q.push_back(len < int'(line_max) ? len : int'(line_max));
  endtask

  task automatic build_stimulus();
    int         len;
    logic [1:0] c;
    lead_bits = int'(rand_bits(4) % 10);
    add_ctrl(2'b00, 8, 1'b0);
    for (int k = 0; k < n_lines; k++) begin
      if (k == 0 || k == 6) begin
        len = 1;
      end else if (k == 4) begin
        len = long_len;
      end else begin
        len = 1 + int'(rand_bits(8) % 200);
      end
      add_line(len);
      c = 2'(rand_bits(2));
      // Blanking lasts long enough for the reader to drain the line.
      add_ctrl(c, 1 + int'(rand_bits(2)) + exp_len_q[k] / 10, 1'b1);
      // That first token closes the line, so its first pixel sees this code.
      exp_sync_q.push_back(c);
    end
    total_bits = sym_q.size() * 10 + lead_bits;
  endtask

  // About one cycle in eight carries no bit.
  task automatic send_bit(input logic b);
    while (rand_bits(3) == 0) begin
      @(posedge clk);
      bit_en <= 1'b0;
    end
    @(posedge clk);
    serial_bit <= b;
    bit_en     <= 1'b1;
  endtask

  task automatic send_sym(input logic [9:0] code);
    for (int i = 0; i < 10; i++) begin
      send_bit(code[i]);
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    serial_bit = 1'b0;
    bit_en     = 1'b0;
    lfsr_q     = 32'h29601df8;
    enc_cnt    = 0;
    lines_sent = 0;
    lines_out  = 0;
    pix_idx    = 0;
    cur_len    = 0;
    build_stimulus();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < lead_bits; i++) begin
      send_bit(1'(rand_bits(1)));
    end
    foreach (sym_q[s]) begin
      send_sym(sym_q[s]);
      if (close_q[s]) begin
        lines_sent++;
      end
      if (s == 7) begin
        check_eq("locked", 32'(locked), 32'd1);
      end
    end
    @(posedge clk);
    bit_en <= 1'b0;
    wait (lines_out == n_lines);
    repeat (20) @(posedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output checks
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n && pix_valid) begin
      if (pix_idx == 0) begin
        if (lines_out >= lines_sent) begin
          stop_with("pix_valid came before its line was closed.");
        end else begin
          cur_len  = exp_len_q.pop_front();
          exp_sync = exp_sync_q.pop_front();
          check_eq("sync.hsync", 32'(sync.hsync), 32'(exp_sync[0]));
          check_eq("sync.vsync", 32'(sync.vsync), 32'(exp_sync[1]));
        end
      end
      check_eq("pix_data", 32'(pix_data), 32'(exp_byte_q.pop_front()));
      check_eq("line_end", 32'(line_end), 32'(pix_idx == cur_len - 1));
      if (pix_idx == cur_len - 1) begin
        pix_idx = 0;
        lines_out++;
      end else begin
        pix_idx++;
      end
    end else if (rst_n && (pix_idx != 0 || line_end)) begin
      stop_with("pix_valid dropped inside a line, or line_end came alone.");
    end
  end

  initial begin
    wait (total_bits > 0);
    repeat (total_bits * 12 + 1000) @(posedge clk);
    stop_with("Timeout: not all lines came out in time.");
  end

endmodule

/* tmds_line_rx.sv */
`timescale 1ns/10ps

module tmds_line_rx import tmds_pkg::*, video_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       serial_bit,
  input  logic       bit_en,
  output logic       locked,
  output sync_t      sync,
  output logic       pix_valid,
  output logic       line_end,
  output logic [7:0] pix_data
);

  tmds_sym_t            sym;
  logic                 sym_valid;
  tmds_word_t           word;
  logic                 word_valid;
  line_desc_t           line;
  logic                 line_ready;
  logic                 rd_bank;
  logic [pix_idx_w-1:0] rd_idx;
  logic [7:0]           rd_data;

  ////////////////////////////////////////////////////////////////////////////
  // Receive path, serial bits in and whole lines out
  ////////////////////////////////////////////////////////////////////////////

  tmds_deser u_deser (
    .clk        (clk),
    .rst_n      (rst_n),
    .serial_bit (serial_bit),
    .bit_en     (bit_en),
    .sym        (sym),
    .sym_valid  (sym_valid),
    .locked     (locked)
  );

  tmds_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .sym        (sym),
    .sym_valid  (sym_valid),
    .word       (word),
    .word_valid (word_valid),
    .sync       (sync)
  );

  line_buffer u_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .word       (word),
    .word_valid (word_valid),
    .line       (line),
    .line_ready (line_ready),
    .rd_bank    (rd_bank),
    .rd_idx     (rd_idx),
    .rd_data    (rd_data)
  );

  line_reader u_reader (
    .clk        (clk),
    .rst_n      (rst_n),
    .line       (line),
    .line_ready (line_ready),
    .rd_bank    (rd_bank),
    .rd_idx     (rd_idx),
    .rd_data    (rd_data),
    .pix_valid  (pix_valid),
    .pix_data   (pix_data),
    .line_end   (line_end)
  );

endmodule

/* line_reader.sv */
`timescale 1ns/10ps

module line_reader import video_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  line_desc_t           line,
  input  logic                 line_ready,
  output logic                 rd_bank,
  output logic [pix_idx_w-1:0] rd_idx,
  input  logic [7:0]           rd_data,
  output logic                 pix_valid,
  output logic [7:0]           pix_data,
  output logic                 line_end
);

  typedef enum logic {
    R_IDLE,
    R_READ
  } rd_state_e;

  rd_state_e            state;
  logic                 bank_q;
  logic [pix_idx_w-1:0] len_q;
  logic [pix_idx_w-1:0] idx_q;
  logic                 rd_last;

  assign rd_bank = bank_q;
  assign rd_idx  = idx_q;
  assign rd_last = (idx_q == len_q - 1'b1);

  // The RAM answers one cycle after the address, so the strobes are delayed
  // by one register to sit on the returned byte.
  assign pix_data = rd_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= R_IDLE;
      idx_q     <= '0;
      pix_valid <= 1'b0;
      line_end  <= 1'b0;
    end else begin
      pix_valid <= (state == R_READ);
      line_end  <= (state == R_READ) && rd_last;
      case (state)
        R_IDLE: begin
          if (line_ready) begin
            state <= R_READ;
            idx_q <= '0;
          end
        end
        R_READ: begin
          if (rd_last) begin
            state <= R_IDLE;
          end else begin
            idx_q <= idx_q + 1'b1;
          end
        end
        default: state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == R_IDLE && line_ready) begin
      bank_q <= line.bank;
      len_q  <= line.len;
    end
  end

  // A line is drained long before the next one can be received.
  a_idle_on_ready: assert property (@(posedge clk) disable iff (!rst_n)
    line_ready |-> state == R_IDLE);

endmodule

/* line_buffer.sv */
`timescale 1ns/10ps

module line_buffer import tmds_pkg::*, video_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  tmds_word_t           word,
  input  logic                 word_valid,
  output line_desc_t           line,
  output logic                 line_ready,
  input  logic                 rd_bank,
  input  logic [pix_idx_w-1:0] rd_idx,
  output logic [7:0]           rd_data
);

  // Two banks. The writer fills one while the reader drains the other.
  logic [7:0]           mem [2][line_max];

  logic                 wr_bank;
  logic [pix_idx_w-1:0] wr_cnt;
  logic                 in_line;
  logic                 wr_en;
  logic                 line_close;

  // Bytes past line_max are dropped but still keep the line open.
  assign wr_en      = word_valid && word.de && (wr_cnt < line_max);
  assign line_close = word_valid && !word.de && in_line;

  ////////////////////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_bank    <= 1'b0;
      wr_cnt     <= '0;
      in_line    <= 1'b0;
      line_ready <= 1'b0;
    end else begin
      line_ready <= line_close;
      if (line_close) begin
        wr_bank <= !wr_bank;
        wr_cnt  <= '0;
        in_line <= 1'b0;
      end else if (word_valid && word.de) begin
        in_line <= 1'b1;
        if (wr_en) begin
          wr_cnt <= wr_cnt + 1'b1;
        end
      end
    end
  end

  // The descriptor is captured before the bank flips.
  always_ff @(posedge clk) begin
    if (line_close) begin
      line.bank <= wr_bank;
      line.len  <= wr_cnt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_bank][wr_cnt[line_aw-1:0]] <= word.data;
    end
    rd_data <= mem[rd_bank][rd_idx[line_aw-1:0]];
  end

  a_line_len: assert property (@(posedge clk) disable iff (!rst_n)
    line_ready |-> (line.len != '0) && (line.len <= line_max));

endmodule

/* tmds_decode.sv */
`timescale 1ns/10ps

module tmds_decode import tmds_pkg::*, video_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  tmds_sym_t  sym,
  input  logic       sym_valid,
  output tmds_word_t word,
  output logic       word_valid,
  output sync_t      sync
);

  tmds_word_t dec_word;
  logic       is_tok;
  logic [1:0] ctrl_bits;

  // Undo the optional inversion, then the XOR or XNOR chain picked by bit 8.
  function automatic logic [7:0] tmds_data(input logic [sym_w-1:0] code);
    logic [7:0] d;
    logic [7:0] q;
    d    = code[9] ? ~code[7:0] : code[7:0];
    q[0] = d[0];
    for (int i = 1; i < 8; i++) begin
      q[i] = code[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    end
    return q;
  endfunction

  assign is_tok = is_ctrl_tok(sym.code);

  always_comb begin
    dec_word.de   = !is_tok;
    dec_word.ctrl = tok_ctrl(sym.code);
    dec_word.data = is_tok ? 8'h00 : tmds_data(sym.code);
  end

  assign ctrl_bits = dec_word.ctrl;

  always_ff @(posedge clk) begin
    if (sym_valid) begin
      word <= dec_word;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Strobe and sync levels
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_valid <= 1'b0;
      sync       <= '0;
    end else begin
      word_valid <= sym_valid;
      // Sync holds its level through data periods.
      if (sym_valid && is_tok) begin
        sync.hsync <= ctrl_bits[0];
        sync.vsync <= ctrl_bits[1];
      end
    end
  end

endmodule

/* tmds_deser.sv */
`timescale 1ns/10ps

module tmds_deser import tmds_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      serial_bit,
  input  logic      bit_en,
  output tmds_sym_t sym,
  output logic      sym_valid,
  output logic      locked
);

  logic [sym_w-1:0] shift_q;
  logic [sym_w-1:0] shift_d;
  logic [3:0]       phase;
  logic             armed;
  logic             tok_hit;
  logic             phase_end;
  logic             emit;

  // Bits arrive least significant first, so they enter at the top.
  assign shift_d   = {serial_bit, shift_q[sym_w-1:1]};
  assign tok_hit   = is_ctrl_tok(shift_d);
  assign phase_end = (phase == 4'(sym_w - 1));

  // Before lock a symbol goes out only on the confirming token.
  assign emit = bit_en && phase_end && (locked || (armed && tok_hit));

  ////////////////////////////////////////////////////////////////////////////
  // Alignment search and symbol framing
  ////////////////////////////////////////////////////////////////////////////

  // While unlocked, phase counts bits since the most recent token match.
  // A second match exactly ten bits later fixes the boundary.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q   <= '0;
      phase     <= '0;
      armed     <= 1'b0;
      locked    <= 1'b0;
      sym_valid <= 1'b0;
    end else begin
      sym_valid <= emit;
      if (bit_en) begin
        shift_q <= shift_d;
        if (emit) begin
          locked <= 1'b1;
          phase  <= '0;
        end else if (locked) begin
          phase <= phase + 1'b1;
        end else if (tok_hit) begin
          armed <= 1'b1;
          phase <= '0;
        end else if (armed) begin
          if (phase_end) begin
            armed <= 1'b0;
          end else begin
            phase <= phase + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      sym.code <= shift_d;
    end
  end

  // One symbol needs ten taken bits, and at most one bit is taken per clock.
  a_sym_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    sym_valid |=> !sym_valid [*9]);

endmodule

/* video_pkg.sv */
package video_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Line storage limits
  ////////////////////////////////////////////////////////////////////////////

  // Wide enough to hold the count line_max itself, not just an index.
  localparam int pix_idx_w = 11;

  // Longest line kept in one bank. Longer lines are cut to this length.
  localparam logic [pix_idx_w-1:0] line_max = 11'd1024;

  // Address bits needed inside one bank.
  localparam int line_aw = $clog2(line_max);

  ////////////////////////////////////////////////////////////////////////////
  // Line and sync types
  ////////////////////////////////////////////////////////////////////////////

  // Published once per finished line.
  typedef struct packed {
    logic                 bank;
    logic [pix_idx_w-1:0] len;
  } line_desc_t;

  // Field order matches the control code, so {vsync, hsync} equals ctrl.
  typedef struct packed {
    logic vsync;
    logic hsync;
  } sync_t;

endpackage

/* tmds_pkg.sv */
package tmds_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Symbol format
  ////////////////////////////////////////////////////////////////////////////

  // One TMDS character on the wire.
  localparam int sym_w = 10;

  // Control tokens for {C1, C0}.
  // Bit 0 of each token is the first bit on the line.
  localparam logic [sym_w-1:0] tok_c00 = 10'b1101010100;
  localparam logic [sym_w-1:0] tok_c01 = 10'b0010101011;
  localparam logic [sym_w-1:0] tok_c10 = 10'b0101010100;
  localparam logic [sym_w-1:0] tok_c11 = 10'b1010101011;

  // Bit 0 of the code is C0 (hsync) and bit 1 is C1 (vsync).
  typedef enum logic [1:0] {
    CTRL_00 = 2'b00,
    CTRL_01 = 2'b01,
    CTRL_10 = 2'b10,
    CTRL_11 = 2'b11
  } ctrl_e;

  typedef struct packed {
    logic [sym_w-1:0] code;
  } tmds_sym_t;

  // A decoded character. The ctrl field is only meaningful when de is low
  // and data only when de is high.
  typedef struct packed {
    logic       de;
    ctrl_e      ctrl;
    logic [7:0] data;
  } tmds_word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Token lookup
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic is_ctrl_tok(input logic [sym_w-1:0] code);
    return (code == tok_c00) || (code == tok_c01) ||
           (code == tok_c10) || (code == tok_c11);
  endfunction

  // Anything that is not a token maps to CTRL_00.
  function automatic ctrl_e tok_ctrl(input logic [sym_w-1:0] code);
    ctrl_e c;
    case (code)
      tok_c01: c = CTRL_01;
      tok_c10: c = CTRL_10;
      tok_c11: c = CTRL_11;
      default: c = CTRL_00;
    endcase
    return c;
  endfunction

endpackage
